//--- vscale_config.svh
`ifndef VSCALE_CONFIG_SVH
`define VSCALE_CONFIG_SVH

// Memory data and address width
`define VSCALE_XPR_WIDTH 32

// Host control register channel
`define VSCALE_PCR_ADDR_WIDTH 12
`define VSCALE_PCR_DATA_WIDTH 64

// Depth in 32-bit words, so byte addresses wrap at 4 KiB
`define VSCALE_SRAM_WORDS 1024

`endif

//--- vscale_pkg.sv
`include "vscale_config.svh"

package vscale_pkg;

   typedef logic [`VSCALE_XPR_WIDTH-1:0] xpr_t;
   typedef logic [`VSCALE_PCR_DATA_WIDTH-1:0] pcr_data_t;
   typedef logic [$clog2(`VSCALE_SRAM_WORDS)-1:0] word_idx_t;

   // Only single transfers, so BUSY and SEQ never appear
   typedef enum logic [1:0] {
      HTRANS_IDLE   = 2'b00,
      HTRANS_NONSEQ = 2'b10
   } htrans_t;

   typedef enum logic [2:0] {
      HSIZE_BYTE = 3'd0,
      HSIZE_HALF = 3'd1,
      HSIZE_WORD = 3'd2
   } hsize_t;

   typedef enum logic {
      HRESP_OKAY  = 1'b0,
      HRESP_ERROR = 1'b1
   } hresp_t;

   typedef enum logic [`VSCALE_PCR_ADDR_WIDTH-1:0] {
      PCR_MEM_ADDR     = 'd0,
      PCR_MEM_DATA     = 'd1,
      PCR_SCRATCH      = 'd2,
      PCR_ACCESS_COUNT = 'd3
   } pcr_addr_t;

endpackage

//--- vscale_hasti_if.sv
`timescale 1ns/10ps
`include "vscale_config.svh"

interface vscale_hasti_if;

   logic [`VSCALE_XPR_WIDTH-1:0] haddr;
   logic hwrite;
   vscale_pkg::hsize_t hsize;
   vscale_pkg::htrans_t htrans;
   logic [`VSCALE_XPR_WIDTH-1:0] hwdata;
   logic [`VSCALE_XPR_WIDTH-1:0] hrdata;
   logic hready;
   vscale_pkg::hresp_t hresp;

   modport master (
      output haddr, hwrite, hsize, htrans, hwdata,
      input  hrdata, hready, hresp
   );

   modport slave (
      input  haddr, hwrite, hsize, htrans, hwdata,
      output hrdata, hready, hresp
   );

endinterface

//--- vscale_mem_req_if.sv
`timescale 1ns/10ps
`include "vscale_config.svh"

interface vscale_mem_req_if;

   logic cmd_valid;
   logic cmd_write;
   vscale_pkg::word_idx_t cmd_addr;
   logic [`VSCALE_XPR_WIDTH-1:0] cmd_wdata;
   logic cmd_done;   // End of the data phase
   logic [`VSCALE_XPR_WIDTH-1:0] cmd_rdata;

   modport requester (output cmd_valid, cmd_write, cmd_addr, cmd_wdata,
                      input  cmd_done, cmd_rdata);

   modport server (input  cmd_valid, cmd_write, cmd_addr, cmd_wdata,
                   output cmd_done, cmd_rdata);

endinterface

//--- vscale_dp_hasti_sram.sv
`timescale 1ns/10ps
`include "vscale_config.svh"

module vscale_dp_hasti_sram (
   input logic clk,
   input logic reset,
   vscale_hasti_if.slave p0,
   vscale_hasti_if.slave p1
);

   localparam int NPORTS = 2;
   localparam int XW = `VSCALE_XPR_WIDTH;
   localparam int LANES = XW / 8;
   localparam int OFFS_W = $clog2(LANES);
   localparam int IDX_W = $bits(vscale_pkg::word_idx_t);

   logic [XW-1:0] mem [`VSCALE_SRAM_WORDS];

   // Both ports are gathered into arrays so one loop serves them
   logic [NPORTS-1:0] a_valid;
   logic [NPORTS-1:0] a_write;
   vscale_pkg::hsize_t a_size [NPORTS];
   vscale_pkg::word_idx_t a_word [NPORTS];
   logic [OFFS_W-1:0] a_offs [NPORTS];
   logic [XW-1:0] hwdata [NPORTS];
   logic [XW-1:0] hrdata [NPORTS];

   logic [NPORTS-1:0] d_valid;
   logic [NPORTS-1:0] d_write;
   vscale_pkg::word_idx_t d_word [NPORTS];
   logic [LANES-1:0] d_mask [NPORTS];

   function automatic logic [LANES-1:0] lane_mask(input vscale_pkg::hsize_t size,
                                                  input logic [OFFS_W-1:0] offs);
      logic [LANES-1:0] mask;
      case (size)
         vscale_pkg::HSIZE_BYTE: mask = LANES'(1) << offs;
         vscale_pkg::HSIZE_HALF: mask = LANES'(3) << {offs[OFFS_W-1:1], 1'b0};
         default:                mask = '1;
      endcase
      return mask;
   endfunction

   function automatic logic [XW-1:0] merge_lanes(input logic [XW-1:0] old_word,
                                                 input logic [XW-1:0] new_word,
                                                 input logic [LANES-1:0] mask);
      logic [XW-1:0] word;
      word = old_word;
      for (int b = 0; b < LANES; b++) begin
         if (mask[b])
            word[8*b +: 8] = new_word[8*b +: 8];
      end
      return word;
   endfunction

   assign a_valid[0] = (p0.htrans == vscale_pkg::HTRANS_NONSEQ) && p0.hready;
   assign a_write[0] = p0.hwrite;
   assign a_size[0] = p0.hsize;
   assign a_word[0] = p0.haddr[OFFS_W +: IDX_W];
   assign a_offs[0] = p0.haddr[OFFS_W-1:0];
   assign hwdata[0] = p0.hwdata;

   assign a_valid[1] = (p1.htrans == vscale_pkg::HTRANS_NONSEQ) && p1.hready;
   assign a_write[1] = p1.hwrite;
   assign a_size[1] = p1.hsize;
   assign a_word[1] = p1.haddr[OFFS_W +: IDX_W];
   assign a_offs[1] = p1.haddr[OFFS_W-1:0];
   assign hwdata[1] = p1.hwdata;

   // Single-cycle memory, never stalls
   assign p0.hready = 1'b1;
   assign p1.hready = 1'b1;
   assign p0.hresp = vscale_pkg::HRESP_OKAY;
   assign p1.hresp = vscale_pkg::HRESP_OKAY;
   assign p0.hrdata = hrdata[0];
   assign p1.hrdata = hrdata[1];

   always_ff @(posedge clk) begin
      if (reset) begin
         d_valid <= '0;
      end else begin
         d_valid <= a_valid;
      end
   end

   always_ff @(posedge clk) begin
      for (int i = 0; i < NPORTS; i++) begin
         if (a_valid[i]) begin
            d_write[i] <= a_write[i];
            d_word[i] <= a_word[i];
            d_mask[i] <= lane_mask(a_size[i], a_offs[i]);
         end
      end
   end

   // Reads sample the array in the address phase, writes land at the end of the data phase
   always_ff @(posedge clk) begin
      for (int i = 0; i < NPORTS; i++) begin
         if (a_valid[i] && !a_write[i]) begin
            if (d_valid[i] && d_write[i] && d_word[i] == a_word[i])
               hrdata[i] <= merge_lanes(mem[a_word[i]], hwdata[i], d_mask[i]);  // Forwarded
            else
               hrdata[i] <= mem[a_word[i]];
         end
         if (d_valid[i] && d_write[i])
            mem[d_word[i]] <= merge_lanes(mem[d_word[i]], hwdata[i], d_mask[i]);
      end
   end

endmodule

//--- vscale_htif_pcr.sv
`timescale 1ns/10ps
`include "vscale_config.svh"

module vscale_htif_pcr (
   input  logic clk,
   input  logic reset,
   input  logic pcr_req_valid,
   output logic pcr_req_ready,
   input  logic pcr_req_rw,
   input  logic [`VSCALE_PCR_ADDR_WIDTH-1:0] pcr_req_addr,
   input  logic [`VSCALE_PCR_DATA_WIDTH-1:0] pcr_req_data,
   output logic pcr_resp_valid,
   input  logic pcr_resp_ready,
   output logic [`VSCALE_PCR_DATA_WIDTH-1:0] pcr_resp_data,
   vscale_mem_req_if.requester mem
);

   vscale_pkg::pcr_addr_t req_addr;
   vscale_pkg::word_idx_t mem_addr;
   vscale_pkg::pcr_data_t scratch;
   vscale_pkg::xpr_t access_count;
   vscale_pkg::pcr_data_t reg_rdata;
   logic mem_busy;
   logic req_fire;

   assign req_addr = vscale_pkg::pcr_addr_t'(pcr_req_addr);
   assign pcr_req_ready = !mem_busy && !pcr_resp_valid;
   assign req_fire = pcr_req_valid && pcr_req_ready;
   assign mem.cmd_addr = mem_addr;   // Stable while the access is in flight

   // Register reads, writes answer with zero
   always_comb begin
      reg_rdata = '0;
      if (!pcr_req_rw) begin
         case (req_addr)
            vscale_pkg::PCR_MEM_ADDR:     reg_rdata = vscale_pkg::pcr_data_t'(mem_addr);
            vscale_pkg::PCR_SCRATCH:      reg_rdata = scratch;
            vscale_pkg::PCR_ACCESS_COUNT: reg_rdata = vscale_pkg::pcr_data_t'(access_count);
            default:                      reg_rdata = '0;
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         pcr_resp_valid <= 1'b0;
         mem_busy <= 1'b0;
         mem.cmd_valid <= 1'b0;
         mem_addr <= '0;
         scratch <= '0;
         access_count <= '0;
      end else begin
         mem.cmd_valid <= 1'b0;
         if (pcr_resp_valid && pcr_resp_ready)
            pcr_resp_valid <= 1'b0;
         if (mem.cmd_done) begin
            mem_busy <= 1'b0;
            pcr_resp_valid <= 1'b1;
            mem_addr <= mem_addr + 1'b1;   // Wraps at the last word
            access_count <= access_count + 1'b1;
         end
         if (req_fire) begin
            if (req_addr == vscale_pkg::PCR_MEM_DATA) begin
               mem_busy <= 1'b1;
               mem.cmd_valid <= 1'b1;
            end else begin
               pcr_resp_valid <= 1'b1;
            end
            if (pcr_req_rw) begin
               case (req_addr)
                  vscale_pkg::PCR_MEM_ADDR: mem_addr <= vscale_pkg::word_idx_t'(pcr_req_data);
                  vscale_pkg::PCR_SCRATCH:  scratch <= pcr_req_data;
                  default: ;   // Count is read-only, unknown addresses drop the write
               endcase
            end
         end
      end
   end

   always_ff @(posedge clk) begin
      if (req_fire) begin
         mem.cmd_write <= pcr_req_rw;
         mem.cmd_wdata <= pcr_req_data[`VSCALE_XPR_WIDTH-1:0];
         pcr_resp_data <= reg_rdata;
      end
      if (mem.cmd_done)
         pcr_resp_data <= mem.cmd_write ? '0 : vscale_pkg::pcr_data_t'(mem.cmd_rdata);
   end

endmodule

//--- vscale_hasti_bridge.sv
`timescale 1ns/10ps
`include "vscale_config.svh"

module vscale_hasti_bridge (
   input logic clk,
   input logic reset,
   vscale_mem_req_if.server cmd,
   vscale_hasti_if.master bus
);

   localparam int PAD_W = `VSCALE_XPR_WIDTH - $bits(vscale_pkg::word_idx_t) - 2;

   logic data_phase;
   logic [`VSCALE_XPR_WIDTH-1:0] wdata_q;

   // Address phase is the cmd_valid cycle itself
   assign bus.htrans = cmd.cmd_valid ? vscale_pkg::HTRANS_NONSEQ : vscale_pkg::HTRANS_IDLE;
   assign bus.haddr = {{PAD_W{1'b0}}, cmd.cmd_addr, 2'b00};
   assign bus.hwrite = cmd.cmd_write;
   assign bus.hsize = vscale_pkg::HSIZE_WORD;
   assign bus.hwdata = wdata_q;

   // Data phase stretches while the slave holds hready low
   always_ff @(posedge clk) begin
      if (reset) begin
         data_phase <= 1'b0;
      end else begin
         data_phase <= cmd.cmd_valid || (data_phase && !bus.hready);
      end
   end

   always_ff @(posedge clk) begin
      if (cmd.cmd_valid)
         wdata_q <= cmd.cmd_wdata;
   end

   assign cmd.cmd_done = data_phase && bus.hready;
   assign cmd.cmd_rdata = (bus.hresp == vscale_pkg::HRESP_OKAY) ? bus.hrdata : '0;

endmodule

//--- vscale_sim_top.sv
`timescale 1ns/10ps
`include "vscale_config.svh"

module vscale_sim_top (
   input  logic clk,
   input  logic reset,
   input  logic htif_pcr_req_valid,
   output logic htif_pcr_req_ready,
   input  logic htif_pcr_req_rw,
   input  logic [`VSCALE_PCR_ADDR_WIDTH-1:0] htif_pcr_req_addr,
   input  logic [`VSCALE_PCR_DATA_WIDTH-1:0] htif_pcr_req_data,
   output logic htif_pcr_resp_valid,
   input  logic htif_pcr_resp_ready,
   output logic [`VSCALE_PCR_DATA_WIDTH-1:0] htif_pcr_resp_data,
   input  logic [`VSCALE_XPR_WIDTH-1:0] imem_haddr,
   input  logic imem_hwrite,
   input  logic [2:0] imem_hsize,
   input  logic [1:0] imem_htrans,
   input  logic [`VSCALE_XPR_WIDTH-1:0] imem_hwdata,
   output logic [`VSCALE_XPR_WIDTH-1:0] imem_hrdata,
   output logic imem_hready,
   output logic imem_hresp
);

   vscale_hasti_if dmem_bus ();
   vscale_hasti_if imem_bus ();
   vscale_mem_req_if mem_req ();

   // Instruction port comes straight from the pins
   assign imem_bus.haddr = imem_haddr;
   assign imem_bus.hwrite = imem_hwrite;
   assign imem_bus.hsize = vscale_pkg::hsize_t'(imem_hsize);
   assign imem_bus.htrans = vscale_pkg::htrans_t'(imem_htrans);
   assign imem_bus.hwdata = imem_hwdata;
   assign imem_hrdata = imem_bus.hrdata;
   assign imem_hready = imem_bus.hready;
   assign imem_hresp = imem_bus.hresp;

   vscale_htif_pcr htif (
      .clk(clk),
      .reset(reset),
      .pcr_req_valid(htif_pcr_req_valid),
      .pcr_req_ready(htif_pcr_req_ready),
      .pcr_req_rw(htif_pcr_req_rw),
      .pcr_req_addr(htif_pcr_req_addr),
      .pcr_req_data(htif_pcr_req_data),
      .pcr_resp_valid(htif_pcr_resp_valid),
      .pcr_resp_ready(htif_pcr_resp_ready),
      .pcr_resp_data(htif_pcr_resp_data),
      .mem(mem_req.requester)
   );

   vscale_hasti_bridge bridge (
      .clk(clk),
      .reset(reset),
      .cmd(mem_req.server),
      .bus(dmem_bus.master)
   );

   vscale_dp_hasti_sram hasti_mem (
      .clk(clk),
      .reset(reset),
      .p0(dmem_bus.slave),
      .p1(imem_bus.slave)
   );

endmodule

//--- vscale_sim_sva.sv
`timescale 1ns/10ps
`include "vscale_config.svh"

module vscale_sim_sva (
   input logic clk,
   input logic reset,
   input logic req_valid,
   input logic req_ready,
   input logic resp_valid,
   input logic resp_ready,
   input logic [`VSCALE_PCR_DATA_WIDTH-1:0] resp_data,
   input logic imem_hready
);

   logic outstanding;   // A request was taken and its response has not gone out yet

   always_ff @(posedge clk) begin
      if (reset)
         outstanding <= 1'b0;
      else if (req_valid && req_ready)
         outstanding <= 1'b1;
      else if (resp_valid && resp_ready)
         outstanding <= 1'b0;
   end

   hready_high: assert property (@(posedge clk) disable iff (reset) imem_hready)
      else $error("imem_hready went low");

   // A response that is not taken must not move
   resp_held: assert property (@(posedge clk) disable iff (reset)
      resp_valid && !resp_ready |=> resp_valid && $stable(resp_data))
      else $error("held PCR response changed before it was taken");

   ready_blocked: assert property (@(posedge clk) disable iff (reset)
      resp_valid |-> !req_ready)
      else $error("req_ready high while a response is pending");

   no_accept: assert property (@(posedge clk) disable iff (reset)
      outstanding |-> !(req_valid && req_ready))
      else $error("request accepted while a response is pending");

endmodule

bind vscale_sim_top vscale_sim_sva sva_i (
   .clk(clk),
   .reset(reset),
   .req_valid(htif_pcr_req_valid),
   .req_ready(htif_pcr_req_ready),
   .resp_valid(htif_pcr_resp_valid),
   .resp_ready(htif_pcr_resp_ready),
   .resp_data(htif_pcr_resp_data),
   .imem_hready(imem_hready)
);

//--- vscale_sim_tb.sv
`timescale 1ns/10ps
`include "vscale_config.svh"

module vscale_sim_tb;

   localparam int words = `VSCALE_SRAM_WORDS;
   localparam int wait_limit = 200;

   logic clk;
   logic reset;
   logic req_valid;
   logic req_ready;
   logic req_rw;
   logic [`VSCALE_PCR_ADDR_WIDTH-1:0] req_addr;
   logic [`VSCALE_PCR_DATA_WIDTH-1:0] req_data;
   logic resp_valid;
   logic resp_ready;
   logic [`VSCALE_PCR_DATA_WIDTH-1:0] resp_data;
   logic [`VSCALE_XPR_WIDTH-1:0] imem_haddr;
   logic imem_hwrite;
   logic [2:0] imem_hsize;
   logic [1:0] imem_htrans;
   logic [`VSCALE_XPR_WIDTH-1:0] imem_hwdata;
   logic [`VSCALE_XPR_WIDTH-1:0] imem_hrdata;
   logic imem_hready;
   logic imem_hresp;

   // Reference model of the memory and the PCR register map
   logic [31:0] model_mem [words];
   bit model_known [words];
   vscale_pkg::word_idx_t m_mem_addr;
   logic [63:0] m_scratch;
   logic [31:0] m_count;

   int checks;
   int errors;
   int tests;
   int mark;
   int hold_pct;   // Chance in percent that resp_ready is held low

   vscale_sim_top dut_i (
      .clk(clk),
      .reset(reset),
      .htif_pcr_req_valid(req_valid),
      .htif_pcr_req_ready(req_ready),
      .htif_pcr_req_rw(req_rw),
      .htif_pcr_req_addr(req_addr),
      .htif_pcr_req_data(req_data),
      .htif_pcr_resp_valid(resp_valid),
      .htif_pcr_resp_ready(resp_ready),
      .htif_pcr_resp_data(resp_data),
      .imem_haddr(imem_haddr),
      .imem_hwrite(imem_hwrite),
      .imem_hsize(imem_hsize),
      .imem_htrans(imem_htrans),
      .imem_hwdata(imem_hwdata),
      .imem_hrdata(imem_hrdata),
      .imem_hready(imem_hready),
      .imem_hresp(imem_hresp)
   );

   initial begin
      clk = 1'b0;
      forever #10 clk = ~clk;
   end

   task automatic check(input string name, input logic [63:0] expected,
                        input logic [63:0] actual);
      checks++;
      if (actual !== expected) begin
         errors++;
         $display("mismatch at %0t: %s expected %h actual %h", $time, name, expected, actual);
      end
   endtask

   task automatic finish_test(input string name);
      tests++;
      $display("test %0d %s done with %0d errors", tests, name, errors - mark);
      mark = errors;
   endtask

   // Byte lanes follow hsize and the low address bits
   function automatic void model_store(input int word, input int offs, input int size,
                                       input logic [31:0] data);
      for (int b = 0; b < 4; b++) begin
         if (size == 2 || (size == 1 && b / 2 == offs / 2) || (size == 0 && b == offs))
            model_mem[word][8*b +: 8] = data[8*b +: 8];
      end
      model_known[word] = 1'b1;
   endfunction

   function automatic logic [31:0] rand_addr(input int word, input int size);
      int offs;
      offs = (size == 0) ? $urandom_range(3) : (size == 1) ? 2 * $urandom_range(1) : 0;
      return 32'(word * 4 + offs);
   endfunction

   task automatic host_access(input logic rw, input logic [11:0] addr, input logic [63:0] data,
                              output logic [63:0] rdata);
      int t;
      bit got;
      bit held;
      logic [63:0] held_data;
      t = 0;
      got = 1'b0;
      held = 1'b0;
      held_data = '0;
      rdata = 'x;
      @(posedge clk);
      req_valid <= 1'b1;
      req_rw <= rw;
      req_addr <= addr;
      req_data <= data;
      @(negedge clk);
      check("htif_pcr_resp_valid", 0, resp_valid);   // Previous response must be gone
      while (!req_ready && t < wait_limit) begin
         @(negedge clk);
         t++;
      end
      if (!req_ready) begin
         errors++;
         $display("request to PCR address %0d was never accepted", addr);
         @(posedge clk);
         req_valid <= 1'b0;
      end else begin
         @(posedge clk);
         req_valid <= 1'b0;
         resp_ready <= ($urandom_range(99) >= hold_pct);
         t = 0;
         while (!got && t < wait_limit) begin
            @(negedge clk);
            t++;
            if (held) begin
               check("htif_pcr_resp_valid", 1, resp_valid);
               check("htif_pcr_resp_data", held_data, resp_data);
            end
            held = resp_valid && !resp_ready;
            held_data = resp_data;
            if (resp_valid && resp_ready) begin
               got = 1'b1;
               rdata = resp_data;
            end else begin
               @(posedge clk);
               resp_ready <= ($urandom_range(99) >= hold_pct);
            end
         end
         if (!got) begin
            errors++;
            $display("no response came for PCR address %0d", addr);
         end
      end
   endtask

   task automatic host_write(input logic [11:0] addr, input logic [63:0] data);
      logic [63:0] resp;
      host_access(1'b1, addr, data, resp);
      check("htif_pcr_resp_data", 0, resp);
   endtask

   task automatic host_read(input logic [11:0] addr, input logic [63:0] expected);
      logic [63:0] resp;
      host_access(1'b0, addr, 64'd0, resp);
      check("htif_pcr_resp_data", expected, resp);
   endtask

   task automatic set_mem_addr(input int idx);
      host_write(vscale_pkg::PCR_MEM_ADDR, 64'(idx));
      m_mem_addr = vscale_pkg::word_idx_t'(idx);
   endtask

   task automatic mem_data_write(input logic [63:0] data);
      host_write(vscale_pkg::PCR_MEM_DATA, data);
      model_store(m_mem_addr, 0, 2, data[31:0]);
      m_mem_addr++;
      m_count++;
   endtask

   task automatic mem_data_read();
      host_read(vscale_pkg::PCR_MEM_DATA, {32'd0, model_mem[m_mem_addr]});
      m_mem_addr++;
      m_count++;
   endtask

   // One transfer on the instruction port, the data phase always lasts one cycle
   task automatic imem_access(input logic write, input logic [31:0] addr, input int size,
                              input logic [31:0] wdata);
      @(posedge clk);
      imem_htrans <= vscale_pkg::HTRANS_NONSEQ;
      imem_haddr <= addr;
      imem_hwrite <= write;
      imem_hsize <= 3'(size);
      @(posedge clk);
      imem_htrans <= vscale_pkg::HTRANS_IDLE;
      imem_hwdata <= wdata;
      @(negedge clk);
      if (write)
         model_store(addr[11:2], addr[1:0], size, wdata);
      else
         check("imem_hrdata", model_mem[addr[11:2]], imem_hrdata);
      check("imem_hresp", 0, imem_hresp);
   endtask

   // Word read issued in the data phase of a write to the same word
   task automatic write_then_read(input logic [31:0] addr, input int size,
                                  input logic [31:0] wdata);
      @(posedge clk);
      imem_htrans <= vscale_pkg::HTRANS_NONSEQ;
      imem_haddr <= addr;
      imem_hwrite <= 1'b1;
      imem_hsize <= 3'(size);
      @(posedge clk);
      imem_hwdata <= wdata;
      imem_haddr <= {addr[31:2], 2'b00};
      imem_hwrite <= 1'b0;
      imem_hsize <= vscale_pkg::HSIZE_WORD;
      @(posedge clk);
      imem_htrans <= vscale_pkg::HTRANS_IDLE;
      @(negedge clk);
      model_store(addr[11:2], addr[1:0], size, wdata);
      check("imem_hrdata", model_mem[addr[11:2]], imem_hrdata);
   endtask

   initial begin
      int w;
      int size;
      void'($urandom(32'hf2dceaec));
      reset = 1'b1;
      req_valid = 1'b0;
      req_rw = 1'b0;
      req_addr = '0;
      req_data = '0;
      resp_ready = 1'b0;
      imem_haddr = '0;
      imem_hwrite = 1'b0;
      imem_hsize = '0;
      imem_htrans = '0;
      imem_hwdata = '0;
      checks = 0;
      errors = 0;
      tests = 0;
      mark = 0;
      hold_pct = 25;
      m_mem_addr = '0;
      m_scratch = '0;
      m_count = '0;
      repeat (5) @(posedge clk);
      reset <= 1'b0;
      @(negedge clk);
      check("htif_pcr_req_ready", 1, req_ready);
      check("imem_hready", 1, imem_hready);

      for (int i = 0; i < 8; i++) begin
         m_scratch = {$urandom, $urandom};
         host_write(vscale_pkg::PCR_SCRATCH, m_scratch);
         host_read(vscale_pkg::PCR_SCRATCH, m_scratch);
         host_read(12'(4 + $urandom_range(4091)), 64'd0);
      end
      host_write(12'(4 + $urandom_range(4091)), {$urandom, $urandom});
      host_read(vscale_pkg::PCR_SCRATCH, m_scratch);
      finish_test("scratch register");

      set_mem_addr(words - 4);   // Runs over the last word and wraps
      repeat (8) mem_data_write({$urandom, $urandom});
      host_read(vscale_pkg::PCR_MEM_ADDR, 64'(m_mem_addr));
      for (int i = 0; i < 8; i++)
         imem_access(1'b0, 32'(((words - 4 + i) % words) * 4), 2, 32'd0);
      finish_test("mem data auto-increment");

      for (int i = 64; i < 80; i++)
         imem_access(1'b1, 32'(i * 4), 2, $urandom);
      repeat (40) begin
         w = 64 + $urandom_range(15);
         size = $urandom_range(2);
         if ($urandom_range(1))
            write_then_read(rand_addr(w, size), size, $urandom);
         else
            imem_access(1'b1, rand_addr(w, size), size, $urandom);
      end
      set_mem_addr(64);
      repeat (16) mem_data_read();
      finish_test("imem byte lanes");

      host_read(vscale_pkg::PCR_ACCESS_COUNT, 64'(m_count));
      host_write(vscale_pkg::PCR_ACCESS_COUNT, {$urandom, $urandom});
      host_read(vscale_pkg::PCR_ACCESS_COUNT, 64'(m_count));
      finish_test("access count");

      hold_pct = 75;
      set_mem_addr(128);
      repeat (32) mem_data_write({$urandom, $urandom});
      repeat (60) begin
         case ($urandom_range(4))
            0: begin
               m_scratch = {$urandom, $urandom};
               host_write(vscale_pkg::PCR_SCRATCH, m_scratch);
            end
            1: host_read(vscale_pkg::PCR_SCRATCH, m_scratch);
            2: set_mem_addr(128 + $urandom_range(31));
            3: begin
               if (m_mem_addr < 128 || m_mem_addr > 159)
                  set_mem_addr(128);
               if ($urandom_range(1))
                  mem_data_write({$urandom, $urandom});
               else
                  mem_data_read();
            end
            default: host_read(vscale_pkg::PCR_MEM_ADDR, 64'(m_mem_addr));
         endcase
      end
      host_read(vscale_pkg::PCR_ACCESS_COUNT, 64'(m_count));
      hold_pct = 25;
      finish_test("response back-pressure");

      fork
         begin
            set_mem_addr(256);
            repeat (32) mem_data_write({$urandom, $urandom});
         end
         begin
            for (int i = 512; i < 544; i++)
               imem_access(1'b1, 32'(i * 4), 2, $urandom);
            repeat (32) begin
               w = 512 + $urandom_range(31);
               size = $urandom_range(2);
               imem_access(1'b1, rand_addr(w, size), size, $urandom);
            end
         end
      join
      for (int i = 0; i < words; i++) begin
         if (model_known[i])
            imem_access(1'b0, 32'(i * 4), 2, 32'd0);
      end
      set_mem_addr(512);
      repeat (32) mem_data_read();
      host_read(vscale_pkg::PCR_ACCESS_COUNT, 64'(m_count));
      finish_test("interleaved traffic");

      $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
      if (errors == 0)
         $display("Everything OK");
      else
         $display("Something failed");
      $finish;
   end

endmodule

//--- all.f
+incdir+.
vscale_pkg.sv
vscale_hasti_if.sv
vscale_mem_req_if.sv
vscale_dp_hasti_sram.sv
vscale_htif_pcr.sv
vscale_hasti_bridge.sv
vscale_sim_top.sv
vscale_sim_sva.sv
vscale_sim_tb.sv

//--- Bender.yml
package:
  name: vscale_sim

export_include_dirs:
  - .

sources:
  - vscale_pkg.sv
  - vscale_hasti_if.sv
  - vscale_mem_req_if.sv
  - vscale_dp_hasti_sram.sv
  - vscale_htif_pcr.sv
  - vscale_hasti_bridge.sv
  - vscale_sim_top.sv
  - target: simulation
    files:
      - vscale_sim_sva.sv
      - vscale_sim_tb.sv
